// File: design/metering_pkg.sv
/*
 * Camera metering package
 * Image geometry, data widths, the statistics register map and the
 * client names used by the write arbiter of the metering subsystem.
 */
package metering_pkg;

    // Square sensor image, pixels per line and lines per frame
    localparam int FRAME_SIZE = 720;

    // Sample and statistics widths
    localparam int PIXEL_BITS = 10;
    localparam int STAT_BITS = 8;

    // Position counters cover one line or one frame
    localparam int COUNTER_BITS = 12;

    // Number of statistics registers
    localparam int STAT_COUNT = 6;

    // Statistics register map
    typedef enum logic [2:0] {
        METER_RED = 3'd0,
        METER_GREEN = 3'd1,
        METER_BLUE = 3'd2,
        PEAK_RED = 3'd3,
        PEAK_GREEN = 3'd4,
        PEAK_BLUE = 3'd5
    } stat_addr_t;

    // Arbiter clients, listed in priority order
    typedef enum logic {
        CLIENT_METER = 1'b0,
        CLIENT_PEAK = 1'b1
    } client_t;

endpackage

// File: design/window_metering.sv
/*
 * Centre-window metering engine
 * Sums each colour channel over a SIZE by SIZE window centred in the
 * frame. At the end of a frame the top byte of each sum is posted to
 * the statistics arbiter, one channel per granted cycle.
 */
`timescale 1ns/1ps

module window_metering
    import metering_pkg::*;
#(
    parameter int SIZE = 512
) (
    input  logic                  clock_in,
    input  logic                  rst,
    input  logic [PIXEL_BITS-1:0] red_in,
    input  logic [PIXEL_BITS-1:0] green_in,
    input  logic [PIXEL_BITS-1:0] blue_in,
    input  logic                  line_valid,
    input  logic                  frame_valid,
    input  logic                  meter_grant,
    output logic                  meter_request,
    output stat_addr_t            meter_address,
    output logic [STAT_BITS-1:0]  meter_data
);

    localparam int WINDOW_START = (FRAME_SIZE / 2) - (SIZE / 2);
    localparam int WINDOW_END = (FRAME_SIZE / 2) + (SIZE / 2);

    // Wide enough for SIZE squared full-scale samples
    localparam int SUM_BITS = $clog2(SIZE * SIZE) + PIXEL_BITS;

    logic [COUNTER_BITS-1:0] x_count;
    logic [COUNTER_BITS-1:0] y_count;
    logic                    previous_line_valid;
    logic                    previous_frame_valid;
    logic [SUM_BITS-1:0]     red_sum;
    logic [SUM_BITS-1:0]     green_sum;
    logic [SUM_BITS-1:0]     blue_sum;
    logic [STAT_BITS-1:0]    red_result;
    logic [STAT_BITS-1:0]    green_result;
    logic [STAT_BITS-1:0]    blue_result;
    logic                    frame_end;
    logic                    in_window;
    logic                    word_done;

    assign frame_end = previous_frame_valid && !frame_valid;
    assign word_done = meter_request && meter_grant;

    assign in_window = line_valid &&
                       x_count >= WINDOW_START && x_count < WINDOW_END &&
                       y_count >= WINDOW_START && y_count < WINDOW_END;

    always_ff @(posedge clock_in) begin
        if (rst) begin
            previous_frame_valid <= 1'b0;
        end else begin
            previous_frame_valid <= frame_valid;
        end
    end

    // Position tracking and window sums, cleared during blanking
    always_ff @(posedge clock_in) begin
        if (rst || !frame_valid) begin
            x_count <= '0;
            y_count <= '0;
            previous_line_valid <= 1'b0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
        end else begin
            previous_line_valid <= line_valid;
            if (line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
                // Next line starts after line_valid falls
                if (previous_line_valid) begin
                    y_count <= y_count + 1'b1;
                end
            end
            if (in_window) begin
                red_sum <= red_sum + red_in;
                green_sum <= green_sum + green_in;
                blue_sum <= blue_sum + blue_in;
            end
        end
    end

    // Top byte of each sum is the window average scaled to 8 bits
    always_ff @(posedge clock_in) begin
        if (frame_end) begin
            red_result <= red_sum[SUM_BITS-1 -: STAT_BITS];
            green_result <= green_sum[SUM_BITS-1 -: STAT_BITS];
            blue_result <= blue_sum[SUM_BITS-1 -: STAT_BITS];
        end
    end

    // Post red, green, then blue while granted
    always_ff @(posedge clock_in) begin
        if (rst) begin
            meter_request <= 1'b0;
            meter_address <= METER_RED;
        end else if (frame_end) begin
            meter_request <= 1'b1;
            meter_address <= METER_RED;
        end else if (word_done) begin
            case (meter_address)
                METER_RED:   meter_address <= METER_GREEN;
                METER_GREEN: meter_address <= METER_BLUE;
                default: begin
                    meter_request <= 1'b0;
                    meter_address <= METER_RED;
                end
            endcase
        end
    end

    always_comb begin
        case (meter_address)
            METER_GREEN: meter_data = green_result;
            METER_BLUE:  meter_data = blue_result;
            default:     meter_data = red_result;
        endcase
    end

    // A word is only ever withdrawn once the arbiter has taken it
    request_held: assert property (@(posedge clock_in) disable iff (rst)
        meter_request && !meter_grant |=> meter_request)
        else $error("meter request dropped without a grant");

    // All three words must be out before the next frame starts
    blanking_long_enough: assert property (@(posedge clock_in) disable iff (rst)
        $rose(frame_valid) |-> !meter_request)
        else $error("new frame started while meter words were pending");

endmodule

// File: design/peak_detector.sv
/*
 * Peak detector
 * Tracks the largest sample of each colour channel over the whole frame
 * and posts the top byte of each maximum to the statistics arbiter.
 */
`timescale 1ns/1ps

module peak_detector
    import metering_pkg::*;
(
    input  logic                  clock_in,
    input  logic                  rst,
    input  logic [PIXEL_BITS-1:0] red_in,
    input  logic [PIXEL_BITS-1:0] green_in,
    input  logic [PIXEL_BITS-1:0] blue_in,
    input  logic                  line_valid,
    input  logic                  frame_valid,
    input  logic                  peak_grant,
    output logic                  peak_request,
    output stat_addr_t            peak_address,
    output logic [STAT_BITS-1:0]  peak_data
);

    logic [PIXEL_BITS-1:0] red_peak;
    logic [PIXEL_BITS-1:0] green_peak;
    logic [PIXEL_BITS-1:0] blue_peak;
    logic [STAT_BITS-1:0]  red_result;
    logic [STAT_BITS-1:0]  green_result;
    logic [STAT_BITS-1:0]  blue_result;
    logic                  previous_frame_valid;
    logic                  frame_end;
    logic                  word_done;

    assign frame_end = previous_frame_valid && !frame_valid;
    assign word_done = peak_request && peak_grant;

    always_ff @(posedge clock_in) begin
        if (rst) begin
            previous_frame_valid <= 1'b0;
        end else begin
            previous_frame_valid <= frame_valid;
        end
    end

    // Running maxima, restarted in every blanking period
    always_ff @(posedge clock_in) begin
        if (rst || !frame_valid) begin
            red_peak <= '0;
            green_peak <= '0;
            blue_peak <= '0;
        end else if (line_valid) begin
            if (red_in > red_peak) red_peak <= red_in;
            if (green_in > green_peak) green_peak <= green_in;
            if (blue_in > blue_peak) blue_peak <= blue_in;
        end
    end

    always_ff @(posedge clock_in) begin
        if (frame_end) begin
            red_result <= red_peak[PIXEL_BITS-1 -: STAT_BITS];
            green_result <= green_peak[PIXEL_BITS-1 -: STAT_BITS];
            blue_result <= blue_peak[PIXEL_BITS-1 -: STAT_BITS];
        end
    end

    // Holds the first word until the meter has finished
    always_ff @(posedge clock_in) begin
        if (rst) begin
            peak_request <= 1'b0;
            peak_address <= PEAK_RED;
        end else if (frame_end) begin
            peak_request <= 1'b1;
            peak_address <= PEAK_RED;
        end else if (word_done) begin
            case (peak_address)
                PEAK_RED:   peak_address <= PEAK_GREEN;
                PEAK_GREEN: peak_address <= PEAK_BLUE;
                default: begin
                    peak_request <= 1'b0;
                    peak_address <= PEAK_RED;
                end
            endcase
        end
    end

    always_comb begin
        case (peak_address)
            PEAK_GREEN: peak_data = green_result;
            PEAK_BLUE:  peak_data = blue_result;
            default:    peak_data = red_result;
        endcase
    end

    request_held: assert property (@(posedge clock_in) disable iff (rst)
        peak_request && !peak_grant |=> peak_request)
        else $error("peak request dropped without a grant");

    blanking_long_enough: assert property (@(posedge clock_in) disable iff (rst)
        $rose(frame_valid) |-> !peak_request)
        else $error("new frame started while peak words were pending");

endmodule

// File: design/stats_arbiter.sv
/*
 * Statistics write arbiter
 * Fixed-priority choice between the metering engine and the peak
 * detector for the single write port of the statistics registers.
 * The metering engine always wins when it requests.
 */
`timescale 1ns/1ps

module stats_arbiter
    import metering_pkg::*;
(
    input  logic                 clock_in,
    input  logic                 rst,
    input  logic                 meter_request,
    input  stat_addr_t           meter_address,
    input  logic [STAT_BITS-1:0] meter_data,
    input  logic                 peak_request,
    input  stat_addr_t           peak_address,
    input  logic [STAT_BITS-1:0] peak_data,
    output logic                 meter_grant,
    output logic                 peak_grant,
    output logic                 write_enable,
    output stat_addr_t           write_address,
    output logic [STAT_BITS-1:0] write_data
);

    client_t winner;

    // Meter has priority, so peak only wins on an idle meter
    assign winner = meter_request ? CLIENT_METER : CLIENT_PEAK;

    assign meter_grant = meter_request && (winner == CLIENT_METER);
    assign peak_grant = peak_request && (winner == CLIENT_PEAK);

    assign write_enable = meter_grant || peak_grant;

    always_comb begin
        if (winner == CLIENT_METER) begin
            write_address = meter_address;
            write_data = meter_data;
        end else begin
            write_address = peak_address;
            write_data = peak_data;
        end
    end

    one_grant: assert property (@(posedge clock_in) disable iff (rst)
        !(meter_grant && peak_grant))
        else $error("both engines granted in one cycle");

    grant_needs_request: assert property (@(posedge clock_in) disable iff (rst)
        (meter_grant |-> meter_request) and (peak_grant |-> peak_request))
        else $error("grant issued without a request");

endmodule

// File: design/stats_registers.sv
/*
 * Statistics register file
 * Six bytes written through one port and read by the host by address.
 * Pulses stats_ready once every sixth write, when a full set is stored.
 */
`timescale 1ns/1ps

module stats_registers
    import metering_pkg::*;
(
    input  logic                 clock_in,
    input  logic                 rst,
    input  logic                 write_enable,
    input  stat_addr_t           write_address,
    input  logic [STAT_BITS-1:0] write_data,
    input  stat_addr_t           read_address,
    output logic [STAT_BITS-1:0] read_data,
    output logic                 stats_ready
);

    logic [STAT_BITS-1:0]          registers [STAT_COUNT];
    logic [$clog2(STAT_COUNT)-1:0] write_count;

    always_ff @(posedge clock_in) begin
        if (rst) begin
            for (int i = 0; i < STAT_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable) begin
            registers[write_address] <= write_data;
        end
    end

    // Counts writes since the last pulse
    always_ff @(posedge clock_in) begin
        if (rst) begin
            write_count <= '0;
            stats_ready <= 1'b0;
        end else begin
            stats_ready <= 1'b0;
            if (write_enable) begin
                if (write_count == STAT_COUNT - 1) begin
                    write_count <= '0;
                    stats_ready <= 1'b1;
                end else begin
                    write_count <= write_count + 1'b1;
                end
            end
        end
    end

    // Unmapped addresses read as zero
    assign read_data = (read_address < STAT_COUNT) ? registers[read_address] : '0;

    address_in_range: assert property (@(posedge clock_in) disable iff (rst)
        write_enable |-> write_address < STAT_COUNT)
        else $error("write to unmapped statistics address");

endmodule

// File: design/camera_metering_top.sv
/*
 * Camera metering subsystem
 * Window metering and peak detection on the incoming pixel stream,
 * sharing one statistics register file through a priority arbiter.
 */
`timescale 1ns/1ps

module camera_metering_top
    import metering_pkg::*;
#(
    parameter int SIZE = 512
) (
    input  logic                  clock_in,
    input  logic                  rst,
    input  logic [PIXEL_BITS-1:0] red_in,
    input  logic [PIXEL_BITS-1:0] green_in,
    input  logic [PIXEL_BITS-1:0] blue_in,
    input  logic                  line_valid,
    input  logic                  frame_valid,
    input  stat_addr_t            read_address,
    output logic [STAT_BITS-1:0]  read_data,
    output logic                  stats_ready
);

    logic                 meter_request;
    logic                 meter_grant;
    stat_addr_t           meter_address;
    logic [STAT_BITS-1:0] meter_data;
    logic                 peak_request;
    logic                 peak_grant;
    stat_addr_t           peak_address;
    logic [STAT_BITS-1:0] peak_data;
    logic                 write_enable;
    stat_addr_t           write_address;
    logic [STAT_BITS-1:0] write_data;

    window_metering #(
        .SIZE(SIZE)
    ) window_metering_inst (
        .clock_in(clock_in),
        .rst(rst),
        .red_in(red_in),
        .green_in(green_in),
        .blue_in(blue_in),
        .line_valid(line_valid),
        .frame_valid(frame_valid),
        .meter_grant(meter_grant),
        .meter_request(meter_request),
        .meter_address(meter_address),
        .meter_data(meter_data)
    );

    peak_detector peak_detector_inst (
        .clock_in(clock_in),
        .rst(rst),
        .red_in(red_in),
        .green_in(green_in),
        .blue_in(blue_in),
        .line_valid(line_valid),
        .frame_valid(frame_valid),
        .peak_grant(peak_grant),
        .peak_request(peak_request),
        .peak_address(peak_address),
        .peak_data(peak_data)
    );

    stats_arbiter stats_arbiter_inst (
        .clock_in(clock_in),
        .rst(rst),
        .meter_request(meter_request),
        .meter_address(meter_address),
        .meter_data(meter_data),
        .peak_request(peak_request),
        .peak_address(peak_address),
        .peak_data(peak_data),
        .meter_grant(meter_grant),
        .peak_grant(peak_grant),
        .write_enable(write_enable),
        .write_address(write_address),
        .write_data(write_data)
    );

    stats_registers stats_registers_inst (
        .clock_in(clock_in),
        .rst(rst),
        .write_enable(write_enable),
        .write_address(write_address),
        .write_data(write_data),
        .read_address(read_address),
        .read_data(read_data),
        .stats_ready(stats_ready)
    );

endmodule

// File: tests/camera_metering_tb.sv
/*
 * Camera metering testbench
 * Plays a table of 720 by 720 frames into the metering subsystem, models
 * the window averages and frame peaks, and reads back the six statistics
 * registers after every stats_ready pulse.
 */
`timescale 1ns/1ps

module camera_metering_tb
    import metering_pkg::*;
();

    localparam int SIZE = 512;
    localparam int RESET_CYCLES = 10;
    localparam int LINE_GAP = 2;
    localparam int FRAME_GAP = 20;
    localparam int FRAME_COUNT = 6;
    localparam int MARGIN = 1000;
    localparam int CYCLE_LIMIT =
        FRAME_COUNT * (FRAME_SIZE * (FRAME_SIZE + LINE_GAP) + FRAME_GAP) +
        RESET_CYCLES + MARGIN;

    // One frame: background level, window level, random pixels
    typedef struct packed {
        logic [PIXEL_BITS-1:0] background;
        logic [PIXEL_BITS-1:0] window;
        logic                  random_pixels;
    } frame_entry_t;

    frame_entry_t frame_table [FRAME_COUNT] = '{
        '{10'd512, 10'd512, 1'b0},
        '{10'd1023, 10'd1023, 1'b0},
        '{10'd1023, 10'd40, 1'b0},
        '{10'd0, 10'd0, 1'b1},
        '{10'd0, 10'd0, 1'b1},
        '{10'd200, 10'd200, 1'b0}
    };

    string register_names [STAT_COUNT] = '{
        "METER_RED", "METER_GREEN", "METER_BLUE",
        "PEAK_RED", "PEAK_GREEN", "PEAK_BLUE"
    };

    logic                  clock_in;
    logic                  rst;
    logic [PIXEL_BITS-1:0] red_in;
    logic [PIXEL_BITS-1:0] green_in;
    logic [PIXEL_BITS-1:0] blue_in;
    logic                  line_valid;
    logic                  frame_valid;
    stat_addr_t            read_address;
    logic [STAT_BITS-1:0]  read_data;
    logic                  stats_ready;

    integer seed;
    int     cycle_count;
    int     pulse_count;
    longint window_sums [3];
    int     frame_peaks [3];
    int     expected_stats [STAT_COUNT];

    camera_metering_top #(
        .SIZE(SIZE)
    ) dut (
        .clock_in(clock_in),
        .rst(rst),
        .red_in(red_in),
        .green_in(green_in),
        .blue_in(blue_in),
        .line_valid(line_valid),
        .frame_valid(frame_valid),
        .read_address(read_address),
        .read_data(read_data),
        .stats_ready(stats_ready)
    );

    initial clock_in = 1'b0;
    always #5 clock_in = ~clock_in;

    // Run limit and stats_ready pulse count
    always @(posedge clock_in) begin
        cycle_count++;
        if (!rst && stats_ready) begin
            pulse_count++;
        end
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic bit in_window(input int x, input int y);
        int low;
        int high;
        low = FRAME_SIZE / 2 - SIZE / 2;
        high = FRAME_SIZE / 2 + SIZE / 2;
        return x >= low && x < high && y >= low && y < high;
    endfunction

    task automatic read_registers();
        for (int i = 0; i < STAT_COUNT; i++) begin
            read_address = stat_addr_t'(i);
            @(negedge clock_in);
            check_value(register_names[i], read_data, expected_stats[i]);
        end
    endtask

    // Plays one frame and updates the reference model per sample
    task automatic send_frame(input int index);
        int r;
        int g;
        int b;
        int level;
        for (int c = 0; c < 3; c++) begin
            window_sums[c] = 0;
            frame_peaks[c] = 0;
        end
        for (int y = 0; y < FRAME_SIZE; y++) begin
            for (int x = 0; x < FRAME_SIZE; x++) begin
                @(negedge clock_in);
                if (frame_table[index].random_pixels) begin
                    r = $random(seed) & 'h3ff;
                    g = $random(seed) & 'h3ff;
                    b = $random(seed) & 'h3ff;
                end else begin
                    level = in_window(x, y) ? frame_table[index].window
                                            : frame_table[index].background;
                    r = level;
                    g = level * 3 / 4;
                    b = level / 2;
                end
                frame_valid = 1'b1;
                line_valid = 1'b1;
                red_in = r;
                green_in = g;
                blue_in = b;
                if (in_window(x, y)) begin
                    window_sums[0] += r;
                    window_sums[1] += g;
                    window_sums[2] += b;
                end
                if (r > frame_peaks[0]) frame_peaks[0] = r;
                if (g > frame_peaks[1]) frame_peaks[1] = g;
                if (b > frame_peaks[2]) frame_peaks[2] = b;
            end
            repeat (LINE_GAP) begin
                @(negedge clock_in);
                line_valid = 1'b0;
                red_in = '0;
                green_in = '0;
                blue_in = '0;
            end
        end
        // Window mean and peak, both scaled down to a statistics byte
        for (int c = 0; c < 3; c++) begin
            expected_stats[c] = (window_sums[c] / (SIZE * SIZE)) >> (PIXEL_BITS - STAT_BITS);
            expected_stats[c + 3] = frame_peaks[c] >> (PIXEL_BITS - STAT_BITS);
        end
    endtask

    // Blanking period with the register readback inside it
    task automatic collect_stats(input int frames_done);
        int used;
        @(negedge clock_in);
        frame_valid = 1'b0;
        used = 1;
        while (pulse_count < frames_done) begin
            @(negedge clock_in);
            used++;
        end
        read_registers();
        used += STAT_COUNT;
        while (used < FRAME_GAP) begin
            @(negedge clock_in);
            used++;
        end
        check_value("stats_ready pulse count", pulse_count, frames_done);
    endtask

    initial begin
        seed = 32046;
        cycle_count = 0;
        pulse_count = 0;
        rst = 1'b1;
        red_in = '0;
        green_in = '0;
        blue_in = '0;
        line_valid = 1'b0;
        frame_valid = 1'b0;
        read_address = METER_RED;
        repeat (RESET_CYCLES) @(negedge clock_in);
        rst = 1'b0;

        // Idle after reset, every register zero and no pulse
        for (int i = 0; i < STAT_COUNT; i++) begin
            expected_stats[i] = 0;
        end
        repeat (4) begin
            @(negedge clock_in);
            check_value("stats_ready while idle", stats_ready, 0);
        end
        read_registers();
        check_value("stats_ready pulse count", pulse_count, 0);

        for (int f = 0; f < FRAME_COUNT; f++) begin
            send_frame(f);
            collect_stats(f + 1);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: files.f
design/metering_pkg.sv
design/window_metering.sv
design/peak_detector.sv
design/stats_arbiter.sv
design/stats_registers.sv
design/camera_metering_top.sv
tests/camera_metering_tb.sv

// File: Bender.yml
package:
  name: camera_metering

sources:
  - design/metering_pkg.sv
  - design/window_metering.sv
  - design/peak_detector.sv
  - design/stats_arbiter.sv
  - design/stats_registers.sv
  - design/camera_metering_top.sv
  - target: test
    files:
      - tests/camera_metering_tb.sv
